// File: design/core_pkg.sv
`default_nettype none

package core_pkg;

    // major opcodes handled by the core
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_ALU,
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_e;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [6:0]  opcode;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
    } dec1_t;

    // op_imm marks the register-immediate ALU form
    typedef struct packed {
        logic [31:0] pc;
        op_class_e   cls;
        alu_op_e     alu_op;
        logic        op_imm;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  funct3;
        logic [31:0] imm;
    } dec2_t;

    typedef struct packed {
        dec2_t dec;
        logic  fwd_rs1;
        logic  fwd_rs2;
        logic  a_pc;
        logic  b_imm;
    } issue_t;

endpackage

`default_nettype wire

// File: design/fetch.sv
`timescale 1ns/10ps
`default_nettype none

module fetch #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  wire logic             CLK,
    input  wire logic             RST,
    input  wire logic             mem_wait,
    input  wire logic             inst_rvalid,
    input  wire logic [31:0]      inst_rdata,
    input  wire logic             jmp_do,
    input  wire logic [31:0]      jmp_pc,
    output logic                  inst_rden,
    output logic [31:0]           inst_raddr,
    output logic                  fetch_valid,
    output core_pkg::fetch_t      fetch
);

    logic        accept;
    logic [31:0] req_pc;

    assign accept = inst_rden && !mem_wait;

    always_ff @(posedge CLK) begin
        if (RST) begin
            inst_rden  <= 1'b0;
            inst_raddr <= RESET_PC - 32'd4;
        end else begin
            inst_rden <= 1'b1;
            // a redirect wins over mem_wait
            if (jmp_do) begin
                inst_raddr <= jmp_pc;
            end else if (accept || !inst_rden) begin
                inst_raddr <= inst_raddr + 32'd4;
            end
        end
    end

    // address of the request answered next cycle
    always_ff @(posedge CLK) begin
        if (accept) begin
            req_pc <= inst_raddr;
        end
    end

    assign fetch_valid = inst_rvalid;
    assign fetch.pc    = req_pc;
    assign fetch.inst  = inst_rdata;

endmodule

`default_nettype wire

// File: design/decode_1st.sv
`timescale 1ns/10ps
`default_nettype none

module decode_1st (
    input  wire logic             CLK,
    input  wire logic             RST,
    input  wire logic             fetch_valid,
    input  wire core_pkg::fetch_t fetch,
    input  wire logic             jmp_do,
    output logic                  dec1_valid,
    output core_pkg::dec1_t       dec1
);

    logic        squash;
    logic [31:0] inst;

    assign inst = fetch.inst;

    // responses at the redirect edge and the one after are wrong path
    always_ff @(posedge CLK) begin
        if (RST) begin
            squash     <= 1'b0;
            dec1_valid <= 1'b0;
        end else begin
            squash     <= jmp_do;
            dec1_valid <= fetch_valid && !jmp_do && !squash;
        end
    end

    always_ff @(posedge CLK) begin
        dec1.pc     <= fetch.pc;
        dec1.opcode <= inst[6:0];
        dec1.rd     <= inst[11:7];
        dec1.funct3 <= inst[14:12];
        dec1.rs1    <= inst[19:15];
        dec1.rs2    <= inst[24:20];
        dec1.funct7 <= inst[31:25];
        // sign-extended immediates
        dec1.imm_i  <= {{20{inst[31]}}, inst[31:20]};
        dec1.imm_b  <= {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        dec1.imm_u  <= {inst[31:12], 12'h000};
        dec1.imm_j  <= {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    end

endmodule

`default_nettype wire

// File: design/decode_2nd.sv
`timescale 1ns/10ps
`default_nettype none

module decode_2nd (
    input  wire logic            CLK,
    input  wire logic            RST,
    input  wire logic            dec1_valid,
    input  wire core_pkg::dec1_t dec1,
    input  wire logic            jmp_do,
    output logic                 dec2_valid,
    output core_pkg::dec2_t      dec2
);

    import core_pkg::*;

    op_class_e   cls;
    alu_op_e     alu_op;
    logic        op_imm;
    logic        alt;
    logic [31:0] imm;

    always_comb begin
        cls    = CLS_NONE;
        op_imm = 1'b0;
        case (dec1.opcode)
            OPC_OP_IMM: begin
                cls    = CLS_ALU;
                op_imm = 1'b1;
            end
            OPC_OP:     cls = CLS_ALU;
            OPC_LUI:    cls = CLS_LUI;
            OPC_AUIPC:  cls = CLS_AUIPC;
            OPC_JAL:    cls = CLS_JAL;
            OPC_JALR:   cls = CLS_JALR;
            OPC_BRANCH: cls = CLS_BRANCH;
            default:    cls = CLS_NONE;
        endcase
    end

    // funct7 bit 5 picks SUB and SRA, but ADDI never subtracts
    assign alt = dec1.funct7[5] && (!op_imm || dec1.funct3 == 3'b101);

    always_comb begin
        alu_op = ALU_ADD;
        if (cls == CLS_ALU) begin
            case (dec1.funct3)
                3'b000:  alu_op = alt ? ALU_SUB : ALU_ADD;
                3'b001:  alu_op = ALU_SLL;
                3'b010:  alu_op = ALU_SLT;
                3'b011:  alu_op = ALU_SLTU;
                3'b100:  alu_op = ALU_XOR;
                3'b101:  alu_op = alt ? ALU_SRA : ALU_SRL;
                3'b110:  alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    always_comb begin
        case (cls)
            CLS_LUI, CLS_AUIPC: imm = dec1.imm_u;
            CLS_JAL:            imm = dec1.imm_j;
            CLS_BRANCH:         imm = dec1.imm_b;
            default:            imm = dec1.imm_i;
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            dec2_valid <= 1'b0;
        end else begin
            dec2_valid <= dec1_valid && !jmp_do;
        end
    end

    always_ff @(posedge CLK) begin
        dec2.pc     <= dec1.pc;
        dec2.cls    <= cls;
        dec2.alu_op <= alu_op;
        dec2.op_imm <= op_imm;
        // branches and unknown opcodes never write
        dec2.rd     <= (cls == CLS_BRANCH || cls == CLS_NONE) ? 5'd0 : dec1.rd;
        dec2.rs1    <= dec1.rs1;
        dec2.rs2    <= dec1.rs2;
        dec2.funct3 <= dec1.funct3;
        dec2.imm    <= imm;
    end

endmodule

`default_nettype wire

// File: design/schedule_1st.sv
`timescale 1ns/10ps
`default_nettype none

module schedule_1st (
    input  wire logic            CLK,
    input  wire logic            RST,
    input  wire logic            dec2_valid,
    input  wire core_pkg::dec2_t dec2,
    input  wire logic            jmp_do,
    output logic                 issue_valid,
    output core_pkg::issue_t     issue
);

    import core_pkg::*;

    logic last_wr;
    logic fwd_rs1;
    logic fwd_rs2;
    logic a_pc;
    logic b_imm;

    // the last issued instruction sits in our own output register
    assign last_wr = issue_valid && (issue.dec.rd != 5'd0);
    assign fwd_rs1 = last_wr && (dec2.rs1 == issue.dec.rd);
    assign fwd_rs2 = last_wr && (dec2.rs2 == issue.dec.rd);

    // PC feeds operand A for auipc and the jump links
    assign a_pc  = dec2.cls inside {CLS_AUIPC, CLS_JAL, CLS_JALR};
    assign b_imm = (dec2.cls == CLS_ALU) ? dec2.op_imm : (dec2.cls inside {CLS_LUI, CLS_AUIPC});

    always_ff @(posedge CLK) begin
        if (RST) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= dec2_valid && !jmp_do;
        end
    end

    always_ff @(posedge CLK) begin
        issue.dec     <= dec2;
        issue.fwd_rs1 <= fwd_rs1;
        issue.fwd_rs2 <= fwd_rs2;
        issue.a_pc    <= a_pc;
        issue.b_imm   <= b_imm;
    end

endmodule

`default_nettype wire

// File: design/register.sv
`timescale 1ns/10ps
`default_nettype none

module register (
    input  wire logic        CLK,
    input  wire logic        RST,
    input  wire logic [4:0]  rs1_addr,
    input  wire logic [4:0]  rs2_addr,
    input  wire logic        wr_en,
    input  wire logic [4:0]  wr_rd,
    input  wire logic [31:0] wr_data,
    output logic [31:0]      rs1_data,
    output logic [31:0]      rs2_data
);

    // x0 has no storage
    logic [31:0] regs [1:31];

    function automatic logic [31:0] read_port(input logic [4:0] addr);
        logic [31:0] value;
        if (addr == 5'd0) begin
            value = 32'd0;
        end else if (wr_en && wr_rd == addr) begin
            value = wr_data;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge CLK) begin
        if (wr_en && wr_rd != 5'd0) begin
            regs[wr_rd] <= wr_data;
        end
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            rs1_data <= 32'd0;
            rs2_data <= 32'd0;
        end else begin
            rs1_data <= read_port(rs1_addr);
            rs2_data <= read_port(rs2_addr);
        end
    end

endmodule

`default_nettype wire

// File: design/exec.sv
`timescale 1ns/10ps
`default_nettype none

module exec (
    input  wire logic             CLK,
    input  wire logic             RST,
    input  wire logic             issue_valid,
    input  wire core_pkg::issue_t issue,
    input  wire logic [31:0]      rs1_data,
    input  wire logic [31:0]      rs2_data,
    output logic                  wr_en,
    output logic [4:0]            wr_rd,
    output logic [31:0]           wr_data,
    output logic                  jmp_do,
    output logic [31:0]           jmp_pc,
    output logic                  retire_valid,
    output logic [31:0]           retire_pc,
    output logic [4:0]            retire_rd,
    output logic [31:0]           retire_data
);

    import core_pkg::*;

    dec2_t       dec;
    logic        in_valid;
    logic        taken;
    logic        is_jump;
    logic [31:0] rs1_val;
    logic [31:0] rs2_val;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic [31:0] result;
    logic [31:0] target;

    assign dec = issue.dec;

    // the slot after a redirect is wrong path
    assign in_valid = issue_valid && !jmp_do;

    // older result comes straight from the output register
    assign rs1_val = issue.fwd_rs1 ? wr_data : rs1_data;
    assign rs2_val = issue.fwd_rs2 ? wr_data : rs2_data;
    assign op_a    = issue.a_pc ? dec.pc : rs1_val;
    assign op_b    = issue.b_imm ? dec.imm : rs2_val;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << op_b[4:0];
            ALU_SLT:  alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {31'd0, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> op_b[4:0];
            ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
            ALU_OR:   alu_res = op_a | op_b;
            default:  alu_res = op_a & op_b;
        endcase
    end

    // branch condition from funct3
    always_comb begin
        case (dec.funct3)
            3'b000:  taken = (rs1_val == rs2_val);
            3'b001:  taken = (rs1_val != rs2_val);
            3'b100:  taken = ($signed(rs1_val) < $signed(rs2_val));
            3'b101:  taken = ($signed(rs1_val) >= $signed(rs2_val));
            3'b110:  taken = (rs1_val < rs2_val);
            3'b111:  taken = (rs1_val >= rs2_val);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        case (dec.cls)
            CLS_ALU, CLS_AUIPC: result = alu_res;
            CLS_LUI:            result = op_b;
            CLS_JAL, CLS_JALR:  result = op_a + 32'd4;
            default:            result = 32'd0;
        endcase
    end

    assign is_jump = (dec.cls == CLS_JAL) || (dec.cls == CLS_JALR)
                   || (dec.cls == CLS_BRANCH && taken);

    assign target = (dec.cls == CLS_JALR) ? ((rs1_val + dec.imm) & ~32'd1)
                                          : (dec.pc + dec.imm);

    always_ff @(posedge CLK) begin
        if (RST) begin
            retire_valid <= 1'b0;
            jmp_do       <= 1'b0;
        end else begin
            retire_valid <= in_valid;
            jmp_do       <= in_valid && is_jump;
        end
    end

    always_ff @(posedge CLK) begin
        retire_pc   <= dec.pc;
        retire_rd   <= dec.rd;
        // x0 stays zero in the retire stream as well
        retire_data <= (dec.rd == 5'd0) ? 32'd0 : result;
        jmp_pc      <= target;
    end

    assign wr_en   = retire_valid && (retire_rd != 5'd0);
    assign wr_rd   = retire_rd;
    assign wr_data = retire_data;

endmodule

`default_nettype wire

// File: design/core.sv
`timescale 1ns/10ps
`default_nettype none

module core #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input  wire         CLK,
    input  wire         RST,

    // instruction port
    output logic        inst_rden,
    output logic [31:0] inst_raddr,
    input  wire         inst_rvalid,
    input  wire  [31:0] inst_rdata,

    // data port, tied off
    output logic        data_rden,
    output logic [31:0] data_raddr,
    input  wire         data_rvalid,
    input  wire  [31:0] data_rdata,

    input  wire         mem_wait,

    // retire
    output logic        retire_valid,
    output logic [31:0] retire_pc,
    output logic [4:0]  retire_rd,
    output logic [31:0] retire_data
);

    import core_pkg::*;

    logic        fetch_valid;
    fetch_t      fetch_word;
    logic        dec1_valid;
    dec1_t       dec1;
    logic        dec2_valid;
    dec2_t       dec2;
    logic        issue_valid;
    issue_t      issue;
    logic [31:0] rs1_data;
    logic [31:0] rs2_data;
    logic        wr_en;
    logic [4:0]  wr_rd;
    logic [31:0] wr_data;
    logic        jmp_do;
    logic [31:0] jmp_pc;

    assign data_rden  = 1'b0;
    assign data_raddr = 32'd0;

    fetch #(
        .RESET_PC    (RESET_PC)
    ) fetch (
        .CLK         (CLK),
        .RST         (RST),
        .mem_wait    (mem_wait),
        .inst_rvalid (inst_rvalid),
        .inst_rdata  (inst_rdata),
        .jmp_do      (jmp_do),
        .jmp_pc      (jmp_pc),
        .inst_rden   (inst_rden),
        .inst_raddr  (inst_raddr),
        .fetch_valid (fetch_valid),
        .fetch       (fetch_word)
    );

    decode_1st decode_1st (
        .CLK         (CLK),
        .RST         (RST),
        .fetch_valid (fetch_valid),
        .fetch       (fetch_word),
        .jmp_do      (jmp_do),
        .dec1_valid  (dec1_valid),
        .dec1        (dec1)
    );

    decode_2nd decode_2nd (
        .CLK         (CLK),
        .RST         (RST),
        .dec1_valid  (dec1_valid),
        .dec1        (dec1),
        .jmp_do      (jmp_do),
        .dec2_valid  (dec2_valid),
        .dec2        (dec2)
    );

    schedule_1st schedule_1st (
        .CLK         (CLK),
        .RST         (RST),
        .dec2_valid  (dec2_valid),
        .dec2        (dec2),
        .jmp_do      (jmp_do),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    // read alongside schedule_1st so the data lines up with its output
    register register (
        .CLK         (CLK),
        .RST         (RST),
        .rs1_addr    (dec2.rs1),
        .rs2_addr    (dec2.rs2),
        .wr_en       (wr_en),
        .wr_rd       (wr_rd),
        .wr_data     (wr_data),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data)
    );

    exec exec (
        .CLK          (CLK),
        .RST          (RST),
        .issue_valid  (issue_valid),
        .issue        (issue),
        .rs1_data     (rs1_data),
        .rs2_data     (rs2_data),
        .wr_en        (wr_en),
        .wr_rd        (wr_rd),
        .wr_data      (wr_data),
        .jmp_do       (jmp_do),
        .jmp_pc       (jmp_pc),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

`default_nettype wire

// File: testbench/core_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module core_assertions #(
    parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
    input wire logic        CLK,
    input wire logic        RST,
    input wire logic        inst_rden,
    input wire logic [31:0] inst_raddr,
    input wire logic        mem_wait,
    input wire logic        jmp_do,
    input wire logic [31:0] jmp_pc,
    input wire logic        retire_valid,
    input wire logic        data_rden,
    input wire logic [31:0] data_raddr
);

    int fail_count = 0;

    // nothing fetched or retired while in reset
    reset_quiet: assert property (@(posedge CLK) RST |=> (!inst_rden && !retire_valid))
        else begin
            fail_count++;
            $error("fetch or retire active during reset");
        end

    // first request after reset
    first_req: assert property (@(posedge CLK)
        (!RST && $past(RST)) |=> (inst_rden && inst_raddr == RESET_PC))
        else begin
            fail_count++;
            $error("first request not at the reset address");
        end

    advance: assert property (@(posedge CLK) disable iff (RST)
        (inst_rden && !mem_wait && !jmp_do) |=> (inst_raddr == $past(inst_raddr) + 32'd4))
        else begin
            fail_count++;
            $error("request address did not advance by 4");
        end

    // mem_wait only stalls the request
    hold: assert property (@(posedge CLK) disable iff (RST)
        (inst_rden && mem_wait && !jmp_do) |=> (inst_rden && inst_raddr == $past(inst_raddr)))
        else begin
            fail_count++;
            $error("request changed while memory was waiting");
        end

    redirect: assert property (@(posedge CLK) disable iff (RST)
        jmp_do |=> (inst_raddr == $past(jmp_pc)))
        else begin
            fail_count++;
            $error("fetch did not follow the jump target");
        end

    // no loads or stores, so the data port stays idle
    data_idle: assert property (@(posedge CLK) !data_rden && data_raddr == 32'd0)
        else begin
            fail_count++;
            $error("data port was not held idle");
        end

endmodule

bind core core_assertions #(.RESET_PC(RESET_PC)) chk_i (
    .CLK          (CLK),
    .RST          (RST),
    .inst_rden    (inst_rden),
    .inst_raddr   (inst_raddr),
    .mem_wait     (mem_wait),
    .jmp_do       (jmp_do),
    .jmp_pc       (jmp_pc),
    .retire_valid (retire_valid),
    .data_rden    (data_rden),
    .data_raddr   (data_raddr)
);

`default_nettype wire

// File: testbench/tb_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_core;

    import core_pkg::*;

    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam logic [31:0] SEED = 32'h0555352c;
    localparam int RAND_LEN = 232;
    localparam int CTRL_LEN = 40;
    localparam int X0_LEN = 12;
    localparam int WATCH_CYCLES = (2 * RAND_LEN + CTRL_LEN + X0_LEN) * 20;

    logic CLK, RST, inst_rvalid, data_rvalid, mem_wait;
    logic [31:0] inst_rdata, data_rdata;
    logic inst_rden, data_rden, retire_valid;
    logic [31:0] inst_raddr, data_raddr, retire_pc, retire_data;
    logic [4:0] retire_rd;

    logic [31:0] rom [0:255];
    logic [31:0] gpr [0:31];
    logic [31:0] rng, wait_rng, seed_save, model_pc, next_pc, halt_pc, exp_data;
    logic [4:0] exp_rd;
    logic wait_on, active, done;
    int prog_len, test_errors, checks, passed, failed;
    string test_name;

    core #(.RESET_PC(RESET_PC)) dut_i (
        .CLK(CLK), .RST(RST),
        .inst_rden(inst_rden), .inst_raddr(inst_raddr),
        .inst_rvalid(inst_rvalid), .inst_rdata(inst_rdata),
        .data_rden(data_rden), .data_raddr(data_raddr),
        .data_rvalid(data_rvalid), .data_rdata(data_rdata),
        .mem_wait(mem_wait),
        .retire_valid(retire_valid), .retire_pc(retire_pc),
        .retire_rd(retire_rd), .retire_data(retire_data)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] rom_word(input logic [31:0] addr);
        logic [31:0] idx;
        idx = (addr - RESET_PC) >> 2;
        return rom[idx[7:0]];
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input int imm, input logic [4:0] rs1,
            input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
        return {imm[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] enc_b(input int off, input logic [4:0] rs2,
            input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input int off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
    endfunction

    // reference ALU straight from the RV32I definitions
    function automatic logic [31:0] alu(input logic [2:0] f3, input logic alt,
            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic put(input logic [31:0] w);
        rom[prog_len] = w;
        prog_len++;
    endtask

    // unused words decode as an unknown opcode
    task automatic clear_rom();
        for (int i = 0; i < 256; i++) begin
            rom[i] = {i[24:0], 7'b0001011};
        end
        prog_len = 0;
    endtask

    task automatic gen_random();
        logic [31:0] r;
        logic [2:0] f3;
        logic alt;
        clear_rom();
        for (int i = 1; i < 32; i++) begin
            rng = xorshift(rng);
            put(enc_i(int'(rng[11:0]), 5'd0, 3'd0, 5'(i), OPC_OP_IMM));
        end
        // registers x0..x7 only, so results are reused at once
        for (int i = 0; i < 200; i++) begin
            rng = xorshift(rng);
            r = rng;
            f3 = r[13:11];
            alt = r[14] && (f3 == 3'd0 || f3 == 3'd5);
            case (r[1:0])
                2'd0: put(enc_r({1'b0, alt, 5'd0}, {2'd0, r[10:8]}, {2'd0, r[7:5]}, f3,
                                {2'd0, r[4:2]}));
                2'd1: begin
                    if (f3 == 3'd1 || f3 == 3'd5) begin
                        put(enc_i(int'({1'b0, f3 == 3'd5 && alt, 5'd0, r[24:20]}),
                                  {2'd0, r[7:5]}, f3, {2'd0, r[4:2]}, OPC_OP_IMM));
                    end else begin
                        put(enc_i(int'(r[31:20]), {2'd0, r[7:5]}, f3, {2'd0, r[4:2]},
                                  OPC_OP_IMM));
                    end
                end
                2'd2: put({r[31:12], 2'd0, r[4:2], OPC_LUI});
                default: put({r[31:12], 2'd0, r[4:2], OPC_AUIPC});
            endcase
        end
        put(enc_j(0, 5'd0));
    endtask

    task automatic gen_control();
        clear_rom();
        put(enc_i(5, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
        put(enc_i(0, 5'd0, 3'd0, 5'd2, OPC_OP_IMM));
        put(enc_i(3, 5'd2, 3'd0, 5'd2, OPC_OP_IMM));
        put(enc_i(-1, 5'd1, 3'd0, 5'd1, OPC_OP_IMM));
        put(enc_b(-8, 5'd0, 5'd1, 3'b001));
        put(enc_i(-2, 5'd0, 3'd0, 5'd3, OPC_OP_IMM));
        put(enc_b(8, 5'd0, 5'd3, 3'b100));
        put(enc_i(99, 5'd0, 3'd0, 5'd4, OPC_OP_IMM));
        put(enc_b(8, 5'd3, 5'd0, 3'b101));
        put(enc_i(77, 5'd0, 3'd0, 5'd4, OPC_OP_IMM));
        put(enc_b(8, 5'd3, 5'd0, 3'b110));
        put(enc_i(55, 5'd0, 3'd0, 5'd5, OPC_OP_IMM));
        put(enc_b(8, 5'd0, 5'd3, 3'b111));
        put(enc_i(44, 5'd0, 3'd0, 5'd5, OPC_OP_IMM));
        put(enc_b(8, 5'd0, 5'd1, 3'b000));
        put(enc_i(33, 5'd0, 3'd0, 5'd6, OPC_OP_IMM));
        // three branches that fall through
        put(enc_b(8, 5'd0, 5'd2, 3'b000));
        put(enc_b(8, 5'd3, 5'd0, 3'b100));
        put(enc_b(8, 5'd2, 5'd2, 3'b001));
        put(enc_j(12, 5'd7));
        put(enc_i(1, 5'd0, 3'd0, 5'd8, OPC_OP_IMM));
        put(enc_i(2, 5'd0, 3'd0, 5'd9, OPC_OP_IMM));
        put({20'd0, 5'd10, OPC_AUIPC});
        put(enc_i(13, 5'd10, 3'd0, 5'd11, OPC_JALR));
        put(enc_i(3, 5'd0, 3'd0, 5'd12, OPC_OP_IMM));
        put(enc_r(7'd0, 5'd11, 5'd7, 3'd0, 5'd13));
        put(enc_j(0, 5'd0));
    endtask

    task automatic gen_x0();
        clear_rom();
        put(enc_i(123, 5'd0, 3'd0, 5'd0, OPC_OP_IMM));
        put(enc_i(7, 5'd0, 3'd0, 5'd1, OPC_OP_IMM));
        put(enc_r(7'd0, 5'd1, 5'd0, 3'd0, 5'd2));
        put({20'hABCDE, 5'd0, OPC_LUI});
        put(enc_r(7'd0, 5'd0, 5'd0, 3'd0, 5'd4));
        put(32'h0040_a083);
        put(32'h0000_00f3);
        put(32'hffff_ffff);
        put(enc_r(7'd0, 5'd2, 5'd1, 3'd0, 5'd5));
        put(enc_i(0, 5'd0, 3'd0, 5'd6, OPC_OP_IMM));
        put(enc_j(0, 5'd0));
    endtask

    task automatic model_step(input logic [31:0] pc, output logic [4:0] rd,
            output logic [31:0] data, output logic [31:0] npc);
        logic [31:0] inst, a, b, imm_i, imm_b;
        logic [2:0] f3;
        logic take;
        inst = rom_word(pc);
        f3 = inst[14:12];
        a = gpr[inst[19:15]];
        b = gpr[inst[24:20]];
        imm_i = {{20{inst[31]}}, inst[31:20]};
        imm_b = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        rd = inst[11:7];
        data = 32'd0;
        npc = pc + 32'd4;
        case (inst[6:0])
            OPC_OP: data = alu(f3, inst[30], a, b);
            OPC_OP_IMM: data = alu(f3, f3 == 3'd5 && inst[30], a, imm_i);
            OPC_LUI: data = {inst[31:12], 12'd0};
            OPC_AUIPC: data = pc + {inst[31:12], 12'd0};
            OPC_JAL: begin
                data = pc + 32'd4;
                npc = pc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            OPC_JALR: begin
                data = pc + 32'd4;
                npc = (a + imm_i) & ~32'd1;
            end
            OPC_BRANCH: begin
                rd = 5'd0;
                case (f3)
                    3'b000: take = a == b;
                    3'b001: take = a != b;
                    3'b100: take = $signed(a) < $signed(b);
                    3'b101: take = $signed(a) >= $signed(b);
                    3'b110: take = a < b;
                    3'b111: take = a >= b;
                    default: take = 1'b0;
                endcase
                if (take) begin
                    npc = pc + imm_b;
                end
            end
            default: rd = 5'd0;
        endcase
        if (rd == 5'd0) begin
            data = 32'd0;
        end else begin
            gpr[rd] = data;
        end
    endtask

    task automatic mismatch(input string what, input logic [31:0] exp, input logic [31:0] act);
        test_errors++;
        $display("mismatch %s %s expected %h actual %h", test_name, what, exp, act);
    endtask

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // instruction memory answers one cycle after acceptance
    always @(posedge CLK) begin
        if (inst_rden && !mem_wait) begin
            inst_rvalid <= 1'b1;
            inst_rdata <= rom_word(inst_raddr);
        end else begin
            inst_rvalid <= 1'b0;
        end
        if (wait_on) begin
            wait_rng = xorshift(wait_rng);
            mem_wait <= (wait_rng % 3 == 0);
        end else begin
            mem_wait <= 1'b0;
        end
    end

    always @(posedge CLK) begin
        if (!RST && active && !done && retire_valid) begin
            model_step(model_pc, exp_rd, exp_data, next_pc);
            checks++;
            assert (retire_pc == model_pc) else mismatch("pc", model_pc, retire_pc);
            assert (retire_rd == exp_rd) else mismatch("rd", 32'(exp_rd), 32'(retire_rd));
            assert (retire_data == exp_data) else mismatch("data", exp_data, retire_data);
            if (model_pc == halt_pc) begin
                done = 1'b1;
            end
            model_pc = next_pc;
        end
    end

    task automatic run_test(input string name);
        int base;
        base = dut_i.chk_i.fail_count;
        RST <= 1'b1;
        repeat (2) @(posedge CLK);
        RST <= 1'b0;
        test_name = name;
        test_errors = 0;
        model_pc = RESET_PC;
        halt_pc = RESET_PC + 32'(4 * (prog_len - 1));
        done = 1'b0;
        active = 1'b1;
        wait (done);
        @(posedge CLK);
        active = 1'b0;
        if (dut_i.chk_i.fail_count != base) begin
            $display("fetch assertion failed during %s", name);
            test_errors++;
        end
        if (test_errors == 0) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %s: %s, %0d errors", name, test_errors == 0 ? "ok" : "failed",
                 test_errors);
    endtask

    initial begin
        RST = 1'b1;
        inst_rvalid = 1'b0;
        inst_rdata = 32'd0;
        data_rvalid = 1'b0;
        data_rdata = 32'd0;
        mem_wait = 1'b0;
        rng = SEED;
        wait_rng = SEED;
        wait_on = 1'b0;
        active = 1'b0;
        done = 1'b0;
        checks = 0;
        passed = 0;
        failed = 0;
        // golden registers start at zero, x0 stays there
        for (int i = 0; i < 32; i++) begin
            gpr[i] = 32'd0;
        end
        seed_save = rng;
        gen_random();
        run_test("alu_random");
        gen_control();
        run_test("control_flow");
        rng = seed_save;
        gen_random();
        wait_on = 1'b1;
        run_test("mem_wait_random");
        wait_on = 1'b0;
        gen_x0();
        run_test("x0_unknown");
        $display("tests %0d, passed %0d, failed %0d, retire checks %0d",
                 passed + failed, passed, failed, checks);
        if (failed == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCH_CYCLES * 100);
        $display("timeout: the core stopped retiring before all tests ended");
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
design/core_pkg.sv
design/fetch.sv
design/decode_1st.sv
design/decode_2nd.sv
design/schedule_1st.sv
design/register.sv
design/exec.sv
design/core.sv
testbench/core_assertions.sv
testbench/tb_core.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_core
FILELIST = filelist.f
LOG      = sim.log

.PHONY: lint sim clean

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
